/* source/quplsPkg.sv */
package quplsPkg;

	// ============================================================
	// Vector types
	// ============================================================

	// Full instruction word as delivered by fetch
	typedef logic [31:0] instruction_t;
	// Architectural register number, wide enough for the special registers
	typedef logic [8:0] aregno_t;
	// Privilege level the instruction runs under, selects the stack pointer
	typedef logic [1:0] operating_mode_t;
	// Index of the micro-op within an expanded instruction
	typedef logic [2:0] uopIdx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [4:0] fnCode_t;
	// Raw register field as encoded in the instruction
	typedef logic [4:0] regField_t;

	// ============================================================
	// Instruction field layout
	// ============================================================

	localparam int OPC_LSB = 0;
	localparam int RT_LSB = 7;
	localparam int RA_LSB = 12;
	localparam int RA_NEG_BIT = 17;
	localparam int RB_LSB = 18;
	localparam int IMMA_BIT = 23;
	localparam int FUNC_LSB = 24;
	// Bits 31 to 29 are spare

	// Opcodes that the operand decode has to tell apart
	localparam opcode_t OP_MOV = 7'h0F;
	localparam opcode_t OP_RTD = 7'h41;
	localparam opcode_t OP_DBRA = 7'h42;
	localparam opcode_t OP_LDX = 7'h50;
	localparam opcode_t OP_STX = 7'h51;

	// Function codes only meaningful under OP_LDX and OP_STX
	localparam fnCode_t FN_LDCTX = 5'h1F;
	localparam fnCode_t FN_STCTX = 5'h1F;

	// Special architectural registers
	localparam aregno_t REG_STACK_BASE = 9'd32;
	localparam aregno_t REG_CTX = 9'd40;
	localparam aregno_t REG_RTD_BASE = 9'd40;
	localparam aregno_t REG_LOOP = 9'd55;
	localparam aregno_t REG_SP_ARCH = 9'd31;

	// A context save or restore walks this many registers, one per micro-op
	localparam int CTX_REGS = 8;
	localparam aregno_t CTX_FIRST_REG = 9'd1;

	// Sequencer states covering both handshakes
	typedef enum logic [1:0] {IDLE, IN_ACK, OUT_REQ, OUT_REL} seqState_t;

	// ============================================================
	// Field extraction
	// ============================================================

	function automatic opcode_t fnOpcode(input instruction_t ir);
		return ir[OPC_LSB +: 7];
	endfunction

	function automatic regField_t fnRtField(input instruction_t ir);
		return ir[RT_LSB +: 5];
	endfunction

	function automatic regField_t fnRaField(input instruction_t ir);
		return ir[RA_LSB +: 5];
	endfunction

	function automatic regField_t fnRbField(input instruction_t ir);
		return ir[RB_LSB +: 5];
	endfunction

	function automatic logic fnRaNeg(input instruction_t ir);
		return ir[RA_NEG_BIT];
	endfunction

	function automatic logic fnImmA(input instruction_t ir);
		return ir[IMMA_BIT];
	endfunction

	function automatic fnCode_t fnFunc(input instruction_t ir);
		return ir[FUNC_LSB +: 5];
	endfunction

	// Context restore is a load with the LDCTX function code
	function automatic logic fnIsLdCtx(input instruction_t ir);
		return (fnOpcode(ir) == OP_LDX) && (fnFunc(ir) == FN_LDCTX);
	endfunction

	function automatic logic fnIsStCtx(input instruction_t ir);
		return (fnOpcode(ir) == OP_STX) && (fnFunc(ir) == FN_STCTX);
	endfunction

endpackage

/* source/decodeRa.sv */
`timescale 1ns/1ns

// Works out the first source register from the held instruction
// Purely combinational, the sequencer keeps its inputs steady
module decodeRa import quplsPkg::*;
(
	input instruction_t heldInstr,
	input operating_mode_t heldOm,
	output aregno_t Ra,
	output logic Raz,
	output logic Ran
);

	regField_t raField;
	opcode_t opcode;
	// Register number before the stack pointer remap
	aregno_t raBase;

	assign raField = fnRaField(heldInstr);
	assign opcode = fnOpcode(heldInstr);

	// ============================================================
	// Opcode specific mapping
	// ============================================================

	always_comb
	begin
		// An immediate in the A slot means no register read at all
		if (fnImmA(heldInstr))
			raBase = '0;
		else if (opcode == OP_RTD)
		begin
			// RTD encodes the return register in the low three bits
			// A zero there means there is nothing to read
			if (raField[2:0] == 3'd0)
				raBase = '0;
			else
				raBase = REG_RTD_BASE + aregno_t'(raField[2:0]);
		end
		else if (opcode == OP_DBRA)
			raBase = REG_LOOP;
		else if (fnIsLdCtx(heldInstr) || fnIsStCtx(heldInstr))
			raBase = REG_CTX;
		else
			raBase = aregno_t'(raField);
	end

	// ============================================================
	// Stack pointer remap
	// ============================================================

	// Each mode has its own stack pointer
	// MOV is left alone so software can reach the raw register
	always_comb
	begin
		if (raBase == REG_SP_ARCH && opcode != OP_MOV)
			Ra = REG_STACK_BASE + aregno_t'(heldOm);
		else
			Ra = raBase;
	end

	assign Raz = (Ra == '0);
	assign Ran = fnRaNeg(heldInstr);   // negate bit passes straight through

endmodule

/* source/decodeRbt.sv */
`timescale 1ns/1ns

// Decodes the second source and the target register
// Context instructions replace one of them with a stepped register number
module decodeRbt import quplsPkg::*;
(
	input instruction_t heldInstr,
	input uopIdx_t uopIdx,
	output aregno_t Rb,
	output aregno_t Rt
);

	// Register addressed by the current micro-op of a context walk
	aregno_t ctxReg;
	logic isLdCtx;
	logic isStCtx;

	assign isLdCtx = fnIsLdCtx(heldInstr);
	assign isStCtx = fnIsStCtx(heldInstr);

	// The walk starts at CTX_FIRST_REG and moves up one per micro-op
	assign ctxReg = CTX_FIRST_REG + aregno_t'(uopIdx);

	// ============================================================
	// Rb
	// ============================================================

	// Context save stores each register in turn, so it sits in Rb
	always_comb
	begin
		if (isStCtx)
			Rb = ctxReg;
		else
			Rb = aregno_t'(fnRbField(heldInstr));
	end

	// ============================================================
	// Rt
	// ============================================================

	// Context restore loads each register in turn, so it is the target
	always_comb
	begin
		if (isLdCtx)
			Rt = ctxReg;
		else
			Rt = aregno_t'(fnRtField(heldInstr));
	end

	// Ordinary instructions see uopIdx at zero, which the walk above
	// ignores anyway since only context instructions use ctxReg

endmodule

/* source/uopCounter.sv */
`timescale 1ns/1ns

// Tracks which micro-op of the held instruction is being presented
module uopCounter import quplsPkg::*;
(
	input logic clk,
	input logic rstN,
	input instruction_t heldInstr,
	input logic ctrStart,
	input logic ctrStep,
	output uopIdx_t uopIdx,
	output logic uopLast
);

	// Micro-ops still to come after the current one
	uopIdx_t remain;
	logic isCtx;

	// Only the context instructions expand, everything else is one micro-op
	assign isCtx = fnIsLdCtx(heldInstr) || fnIsStCtx(heldInstr);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			uopIdx <= '0;
			remain <= '0;
		end
		else if (ctrStart)
		begin
			// heldInstr already holds the new instruction here
			uopIdx <= '0;
			remain <= isCtx ? uopIdx_t'(CTX_REGS - 1) : '0;
		end
		else if (ctrStep)
		begin
			uopIdx <= uopIdx + 3'd1;
			// Stepping off the last micro-op must not wrap the count
			if (remain != '0)
				remain <= remain - 3'd1;
		end
	end

	assign uopLast = (remain == '0);

endmodule

/* source/decodeSeq.sv */
`timescale 1ns/1ns

// Runs the input and output four-phase handshakes
// Holds one instruction until all of its micro-ops have been taken
module decodeSeq import quplsPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inReq,
	input instruction_t instr,
	input operating_mode_t om,
	output logic inAck,
	output logic outReq,
	input logic outAck,
	input logic uopLast,
	output instruction_t heldInstr,
	output operating_mode_t heldOm,
	output logic ctrStart,
	output logic ctrStep
);

	seqState_t state;
	logic capture;

	// Capture happens on the edge that leaves IDLE
	assign capture = (state == IDLE) && inReq;

	// ============================================================
	// State machine
	// ============================================================

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			outReq <= 1'b0;
			ctrStart <= 1'b0;
		end
		else
		begin
			// Counter load lasts exactly the first cycle of IN_ACK
			ctrStart <= capture;
			case (state)
			IDLE:
				if (inReq)
					state <= IN_ACK;
			IN_ACK:
				// Source has released, drop the ack and start presenting
				if (!inReq)
					state <= OUT_REQ;
			OUT_REQ:
				// First cycle here only raises the request
				// This leaves a cycle between inAck falling and outReq rising
				if (!outReq)
					outReq <= 1'b1;
				else if (outAck)
				begin
					outReq <= 1'b0;
					state <= OUT_REL;
				end
			OUT_REL:
				if (!outAck)
				begin
					if (uopLast)
						state <= IDLE;
					else
					begin
						// Next micro-op goes out straight away
						outReq <= 1'b1;
						state <= OUT_REQ;
					end
				end
			default:
				state <= IDLE;
			endcase
		end
	end

	// ============================================================
	// Held operands and counter control
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			heldInstr <= instr;
			heldOm <= om;
		end
	end

	assign inAck = (state == IN_ACK);

	// Advance the counter on the same edge that re-raises outReq
	// so the decoders settle before the sink sees the request
	assign ctrStep = (state == OUT_REL) && !outAck;

endmodule

/* source/decodeUnit.sv */
`timescale 1ns/1ns

// Register operand decode unit
// Takes one instruction per input handshake and hands out one or more
// decoded micro-ops over the output handshake
module decodeUnit import quplsPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inReq,
	output logic inAck,
	input instruction_t instr,
	input operating_mode_t om,
	output logic outReq,
	input logic outAck,
	output aregno_t Ra,
	output logic Raz,
	output logic Ran,
	output aregno_t Rb,
	output aregno_t Rt,
	output logic uopLast
);

	// ============================================================
	// Internal wiring
	// ============================================================

	instruction_t heldInstr;
	operating_mode_t heldOm;
	logic ctrStart;
	logic ctrStep;
	uopIdx_t uopIdx;

	// Handshakes and instruction capture
	decodeSeq uSeq
	(
		.clk(clk),
		.rstN(rstN),
		.inReq(inReq),
		.instr(instr),
		.om(om),
		.inAck(inAck),
		.outReq(outReq),
		.outAck(outAck),
		.uopLast(uopLast),
		.heldInstr(heldInstr),
		.heldOm(heldOm),
		.ctrStart(ctrStart),
		.ctrStep(ctrStep)
	);

	// Micro-op position within the held instruction
	uopCounter uCtr
	(
		.clk(clk),
		.rstN(rstN),
		.heldInstr(heldInstr),
		.ctrStart(ctrStart),
		.ctrStep(ctrStep),
		.uopIdx(uopIdx),
		.uopLast(uopLast)
	);

	// ============================================================
	// Operand decoders
	// ============================================================

	decodeRa uRa
	(
		.heldInstr(heldInstr),
		.heldOm(heldOm),
		.Ra(Ra),
		.Raz(Raz),
		.Ran(Ran)
	);

	decodeRbt uRbt
	(
		.heldInstr(heldInstr),
		.uopIdx(uopIdx),
		.Rb(Rb),
		.Rt(Rt)
	);

endmodule

/* bench/decodeUnitProps.sv */
`timescale 1ns/1ns

// Protocol checks for both four-phase handshakes of the decode unit
// Bound into every decodeUnit instance
module decodeUnitProps import quplsPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inReq,
	input logic inAck,
	input logic outReq,
	input logic outAck,
	input aregno_t Ra,
	input logic Raz,
	input logic Ran,
	input aregno_t Rb,
	input aregno_t Rt,
	input logic uopLast
);

	// ============================================================
	// Reset
	// ============================================================

	// Both handshake outputs sit low while reset is held
	aResetLow: assert property (@(posedge clk) !rstN |-> !inAck && !outReq)
		else $error("inAck or outReq high during reset");

	// ============================================================
	// Input handshake
	// ============================================================

	// The unit only acknowledges a request that is present
	aInAckRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(inAck) |-> inReq)
		else $error("inAck rose without inReq");

	// The ack is withdrawn only once the source has let go
	aInAckFall: assert property (@(posedge clk) disable iff (!rstN)
		$fell(inAck) |-> !$past(inReq))
		else $error("inAck fell before inReq fell");

	// ============================================================
	// Output handshake
	// ============================================================

	// An unanswered request is held
	aOutReqHold: assert property (@(posedge clk) disable iff (!rstN)
		outReq && !outAck |=> outReq)
		else $error("outReq dropped before outAck");

	// Fields do not move from the rise of outReq until outAck falls
	aFieldsStable: assert property (@(posedge clk) disable iff (!rstN)
		$past(outReq || outAck) && (outReq || outAck)
		|-> $stable({Ra, Raz, Ran, Rb, Rt, uopLast}))
		else $error("decoded fields changed during the output handshake");

	aOutReqFall: assert property (@(posedge clk) disable iff (!rstN)
		$fell(outReq) |-> $past(outAck))
		else $error("outReq fell without outAck");

	// A new request waits until the sink has released its ack
	aOutReqRise: assert property (@(posedge clk) disable iff (!rstN)
		$rose(outReq) |-> !$past(outAck))
		else $error("outReq rose while outAck was high");

endmodule

bind decodeUnit decodeUnitProps uProps (.*);

/* bench/tbDecodeUnit.sv */
`timescale 1ns/1ns

module tbDecodeUnit import quplsPkg::*;
();

	localparam int LIMIT = 400;

	logic clk;
	logic rstN;
	logic inReq;
	logic inAck;
	instruction_t instr;
	operating_mode_t om;
	logic outReq;
	logic outAck;
	aregno_t Ra;
	logic Raz;
	logic Ran;
	aregno_t Rb;
	aregno_t Rt;
	logic uopLast;

	// Instruction whose micro-ops are presented now, and the expected position
	instruction_t curInstr;
	operating_mode_t curOm;
	int expIdx;
	int nUops;
	logic [28:0] expVec;
	string testName;
	int errCount;
	int errBase;
	int hsCount;
	int hsBase;
	int predicted;
	int testsPassed;
	int testsFailed;
	logic prevReq;

	decodeUnit uut
	(
		.clk(clk), .rstN(rstN), .inReq(inReq), .inAck(inAck), .instr(instr), .om(om),
		.outReq(outReq), .outAck(outAck), .Ra(Ra), .Raz(Raz), .Ran(Ran), .Rb(Rb),
		.Rt(Rt), .uopLast(uopLast)
	);

	always #2 clk = ~clk;

	// ============================================================
	// Reference model
	// ============================================================

	// Packs {Ra, Raz, Ran, Rb, Rt} from the instruction layout and decode rules
	function automatic logic [28:0] refDecode(input logic [31:0] ir, input logic [1:0] mode,
		input int idx);
		logic [6:0] opc;
		logic [4:0] raF;
		logic [4:0] rbF;
		logic [4:0] rtF;
		logic [4:0] fn;
		logic isLd;
		logic isSt;
		logic [8:0] ra;
		logic [8:0] rb;
		logic [8:0] rt;
		opc = ir[6:0];
		rtF = ir[11:7];
		raF = ir[16:12];
		rbF = ir[22:18];
		fn = ir[28:24];
		isLd = (opc == OP_LDX) && (fn == FN_LDCTX);
		isSt = (opc == OP_STX) && (fn == FN_STCTX);
		if (ir[23])
			ra = 9'd0;
		else if (opc == OP_RTD)
			ra = (raF[2:0] == 3'd0) ? 9'd0 : REG_RTD_BASE + {6'd0, raF[2:0]};
		else if (opc == OP_DBRA)
			ra = REG_LOOP;
		else if (isLd || isSt)
			ra = REG_CTX;
		else
			ra = {4'd0, raF};
		if (ra == REG_SP_ARCH && opc != OP_MOV)
			ra = REG_STACK_BASE + {7'd0, mode};
		rb = isSt ? CTX_FIRST_REG + 9'(idx) : {4'd0, rbF};
		rt = isLd ? CTX_FIRST_REG + 9'(idx) : {4'd0, rtF};
		return {ra, ra == 9'd0, ir[17], rb, rt};
	endfunction

	function automatic int uopCount(input logic [31:0] ir);
		if ((ir[6:0] == OP_LDX && ir[28:24] == FN_LDCTX) ||
			(ir[6:0] == OP_STX && ir[28:24] == FN_STCTX))
			return CTX_REGS;
		return 1;
	endfunction

	function automatic logic [31:0] makeInstr(input logic [6:0] opc, input logic [4:0] rt,
		input logic [4:0] ra, input logic neg, input logic [4:0] rb, input logic imm,
		input logic [4:0] fn);
		return {3'b000, fn, imm, rb, neg, ra, rt, opc};
	endfunction

	always_comb
		expVec = refDecode(curInstr, curOm, expIdx);

	// ============================================================
	// Output checks
	// ============================================================

	aRa: assert property (@(posedge clk) disable iff (!rstN) outReq |-> Ra == expVec[28:20])
		else begin
			$display("mismatch %s Ra expected %0d actual %0d", testName,
				$sampled(expVec[28:20]), $sampled(Ra));
			errCount++;
		end
	aRazRan: assert property (@(posedge clk) disable iff (!rstN)
		outReq |-> {Raz, Ran} == expVec[19:18])
		else begin
			$display("mismatch %s Raz,Ran expected %0b actual %0b", testName,
				$sampled(expVec[19:18]), $sampled({Raz, Ran}));
			errCount++;
		end
	aRb: assert property (@(posedge clk) disable iff (!rstN) outReq |-> Rb == expVec[17:9])
		else begin
			$display("mismatch %s Rb expected %0d actual %0d", testName,
				$sampled(expVec[17:9]), $sampled(Rb));
			errCount++;
		end
	aRt: assert property (@(posedge clk) disable iff (!rstN) outReq |-> Rt == expVec[8:0])
		else begin
			$display("mismatch %s Rt expected %0d actual %0d", testName,
				$sampled(expVec[8:0]), $sampled(Rt));
			errCount++;
		end
	aLast: assert property (@(posedge clk) disable iff (!rstN)
		outReq |-> uopLast == (expIdx == nUops - 1))
		else begin
			$display("mismatch %s uopLast expected %0b actual %0b", testName,
				$sampled(expIdx == nUops - 1), $sampled(uopLast));
			errCount++;
		end

	// Every rise of outReq is one output handshake
	always @(posedge clk)
	begin
		prevReq <= outReq;
		if (rstN && outReq && !prevReq)
			hsCount <= hsCount + 1;
	end

	// ============================================================
	// Handshake tasks
	// ============================================================

	task automatic timeoutFail(input string what);
		$display("timeout in %s while waiting for %s", testName, what);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic waitSignal(input string what, input logic level, input int which);
		int t;
		t = 0;
		@(negedge clk);
		while ((which == 0 ? inAck : outReq) !== level)
		begin
			@(negedge clk);
			t++;
			if (t > LIMIT)
				timeoutFail(what);
		end
	endtask

	task automatic sourceSend(input logic [31:0] ir, input logic [1:0] mode);
		repeat ($urandom % 4) @(posedge clk);
		@(posedge clk);
		inReq <= 1'b1;
		instr <= ir;
		om <= mode;
		waitSignal("inAck high", 1'b1, 0);
		@(posedge clk);
		inReq <= 1'b0;
		waitSignal("inAck low", 1'b0, 0);
	endtask

	task automatic sinkTake(input int n, input int maxDelay);
		for (int i = 0; i < n; i++)
		begin
			waitSignal("outReq high", 1'b1, 1);
			repeat ($urandom % (maxDelay + 1)) @(posedge clk);
			@(posedge clk);
			outAck <= 1'b1;
			waitSignal("outReq low", 1'b0, 1);
			@(posedge clk);
			outAck <= 1'b0;
			expIdx <= expIdx + 1;
		end
	endtask

	task automatic runInstr(input logic [31:0] ir, input logic [1:0] mode, input int maxDelay);
		@(negedge clk);
		curInstr = ir;
		curOm = mode;
		expIdx = 0;
		nUops = uopCount(ir);
		predicted += nUops;
		fork
			sourceSend(ir, mode);
			sinkTake(uopCount(ir), maxDelay);
		join
	endtask

	task automatic startTest(input string name);
		testName = name;
		errBase = errCount;
		hsBase = hsCount;
		predicted = 0;
	endtask

	task automatic endTest();
		repeat (4) @(posedge clk);
		if (hsCount - hsBase != predicted)
		begin
			$display("mismatch %s handshakes expected %0d actual %0d", testName,
				predicted, hsCount - hsBase);
			errCount++;
		end
		if (errCount == errBase)
		begin
			testsPassed++;
			$display("test %s passed", testName);
		end
		else
		begin
			testsFailed++;
			$display("test %s failed with %0d errors", testName, errCount - errBase);
		end
	endtask

	// ============================================================
	// Stimulus
	// ============================================================

	initial
	begin
		logic [6:0] opc;
		logic [4:0] fn;
		logic [4:0] raF;
		void'($urandom(64824));
		clk = 1'b0;
		rstN = 1'b0;
		inReq = 1'b0;
		instr = '0;
		om = '0;
		outAck = 1'b0;
		curInstr = '0;
		curOm = '0;
		expIdx = 0;
		nUops = 1;
		errCount = 0;
		hsCount = 0;
		prevReq = 1'b0;
		testsPassed = 0;
		testsFailed = 0;
		predicted = 0;
		testName = "reset";
		repeat (8) @(posedge clk);
		rstN <= 1'b1;

		startTest("plain");
		for (int i = 0; i < 12; i++)
			runInstr(makeInstr(7'h01 + 7'(i), 5'($urandom), 5'($urandom % 31), 1'($urandom),
				5'($urandom), 1'(i % 2), 5'($urandom)), 2'($urandom), 3);
		endTest();

		startTest("rtd_dbra");
		for (int i = 0; i < 8; i++)
			runInstr(makeInstr(OP_RTD, 5'($urandom), {2'($urandom), 3'(i)}, 1'b0,
				5'($urandom), 1'b0, 5'd0), 2'($urandom), 2);
		runInstr(makeInstr(OP_DBRA, 5'd3, 5'd9, 1'b1, 5'd4, 1'b0, 5'd0), 2'd1, 2);
		endTest();

		startTest("stack_pointer");
		for (int m = 0; m < 4; m++)
		begin
			runInstr(makeInstr(OP_MOV, 5'd2, 5'd31, 1'b0, 5'd5, 1'b0, 5'd0), 2'(m), 2);
			runInstr(makeInstr(7'h02, 5'd2, 5'd31, 1'b0, 5'd5, 1'b0, 5'd0), 2'(m), 2);
		end
		endTest();

		startTest("context");
		runInstr(makeInstr(OP_LDX, 5'd7, 5'd3, 1'b0, 5'd6, 1'b0, FN_LDCTX), 2'd2, 3);
		runInstr(makeInstr(OP_STX, 5'd7, 5'd3, 1'b0, 5'd6, 1'b0, FN_STCTX), 2'd0, 3);
		endTest();

		// Long sink stalls keep outReq and the fields held
		startTest("backpressure");
		runInstr(makeInstr(OP_LDX, 5'd1, 5'd31, 1'b0, 5'd2, 1'b0, FN_LDCTX), 2'd3, 60);
		runInstr(makeInstr(7'h03, 5'd1, 5'd31, 1'b1, 5'd2, 1'b0, 5'd0), 2'd3, 60);
		endTest();

		startTest("random");
		for (int i = 0; i < 200; i++)
		begin
			case ($urandom % 7)
				0: opc = OP_MOV;
				1: opc = OP_RTD;
				2: opc = OP_DBRA;
				3: opc = OP_LDX;
				4: opc = OP_STX;
				default: opc = 7'($urandom);
			endcase
			fn = ($urandom % 2 == 0) ? FN_LDCTX : 5'($urandom);
			raF = ($urandom % 4 == 0) ? 5'd31 : 5'($urandom);
			runInstr(makeInstr(opc, 5'($urandom), raF, 1'($urandom), 5'($urandom),
				1'($urandom % 5 == 0), fn), 2'($urandom), 4);
		end
		endTest();

		$display("tests passed %0d failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0 && errCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* filelist.f */
source/quplsPkg.sv
source/decodeRa.sv
source/decodeRbt.sv
source/uopCounter.sv
source/decodeSeq.sv
source/decodeUnit.sv
bench/decodeUnitProps.sv
bench/tbDecodeUnit.sv

/* Makefile */
.PHONY: all run clean

all: run

obj_dir/VtbDecodeUnit: filelist.f $(wildcard source/*.sv) $(wildcard bench/*.sv)
	verilator --binary --assert --timing -Wno-fatal --top-module tbDecodeUnit -f filelist.f

run: obj_dir/VtbDecodeUnit
	./obj_dir/VtbDecodeUnit | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
